//--- list.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/mem_port_if.sv
rtl/cache_store.sv
rtl/dcache_ctrl.sv
rtl/refill_engine.sv
rtl/writeback_engine.sv
rtl/mem_arbiter.sv
rtl/dcache_top.sv
tests/dcache_props.sv
tests/dcache_tb.sv

//--- rtl/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
`define CACHE_WAYS      4
`define CACHE_WAY_W     2
`define CACHE_INDEX_W   4   // 16 sets
`define CACHE_OFFSET_W  5   // 32-byte lines
`define CACHE_WORDS     8
`define CACHE_WORD_W    3

// bus widths
`define ADDR_W          32
`define DATA_W          32

// tag is what is left of the address above index and offset
`define CACHE_TAG_W     (`ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`endif

//--- rtl/cache_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    typedef logic [`CACHE_WAY_W-1:0]    way_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;
    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_WORD_W-1:0]   word_sel_t;
    typedef logic [`CACHE_WAYS-2:0]     plru_t;     // tree bits b2 b1 b0

    // answer of the store for the held request
    typedef struct packed {
        logic   hit;
        way_t   hit_way;
        way_t   victim_way;
        logic   victim_dirty;
        tag_t   victim_tag;
    } lookup_t;

    // one refill word into the victim way
    typedef struct packed {
        logic               we;
        word_sel_t          word;
        logic [`DATA_W-1:0] data;
    } fill_wr_t;

endpackage

`default_nettype wire

//--- rtl/cache_store.sv
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_store import cache_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lookup_en,
    input  logic                 store_commit,
    input  logic                 cpu_we,
    input  logic [`ADDR_W-1:0]   cpu_addr,
    input  logic [`DATA_W/8-1:0] cpu_be,
    input  logic [`DATA_W-1:0]   cpu_wdata,
    output lookup_t              lookup,
    output logic [`DATA_W-1:0]   cpu_rdata,
    input  fill_wr_t             fill_wr,
    input  way_t                 fill_way,
    input  logic                 fill_valid,
    input  word_sel_t            wb_word,
    output logic [`DATA_W-1:0]   wb_rdata
);

    localparam int SETS = 1 << `CACHE_INDEX_W;

    tag_t               tag_arr  [`CACHE_WAYS][SETS];
    logic [`DATA_W-1:0] data_arr [`CACHE_WAYS][SETS][`CACHE_WORDS];
    logic [SETS-1:0]    valid_arr [`CACHE_WAYS];
    logic [SETS-1:0]    dirty_arr [`CACHE_WAYS];
    plru_t              plru_arr [SETS];

    // snapshot of the set taken in the read cycle
    tag_t                   tag_q  [`CACHE_WAYS];
    logic [`DATA_W-1:0]     data_q [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] valid_q;
    logic [`CACHE_WAYS-1:0] dirty_q;
    plru_t                  plru_q;
    logic                   cmp_q;      // compare cycle
    logic [`CACHE_WAYS-1:0] hit_vec;

    tag_t      tag;
    index_t    index;
    word_sel_t word;
    logic      touch_en;
    way_t      touch_way;

    assign tag   = cpu_addr[`ADDR_W-1 -: `CACHE_TAG_W];
    assign index = cpu_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign word  = cpu_addr[(`CACHE_OFFSET_W - `CACHE_WORD_W) +: `CACHE_WORD_W];

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            plru_q <= plru_arr[index];
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                tag_q[w]   <= tag_arr[w][index];
                valid_q[w] <= valid_arr[w][index];
                dirty_q[w] <= dirty_arr[w][index];
                if (!cpu_we) begin
                    data_q[w] <= data_arr[w][index][word];  // stores need no data
                end
            end
        end
    end

    always_comb begin
        lookup = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = valid_q[w] && (tag_q[w] == tag);
            if (hit_vec[w]) begin
                lookup.hit_way = way_t'(w);
            end
        end
        lookup.hit = |hit_vec;
        // b0 picks the half, b1/b2 the way inside it
        lookup.victim_way   = plru_q[0] ? {1'b1, plru_q[2]} : {1'b0, plru_q[1]};
        lookup.victim_dirty = valid_q[lookup.victim_way] && dirty_q[lookup.victim_way];
        lookup.victim_tag   = tag_q[lookup.victim_way];
    end

    assign cpu_rdata = data_q[lookup.hit_way];
    assign wb_rdata  = data_arr[fill_way][index][wb_word];

    assign touch_en  = fill_valid || (cmp_q && lookup.hit);
    assign touch_way = fill_valid ? fill_way : lookup.hit_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmp_q <= 1'b0;
            for (int s = 0; s < SETS; s++) begin
                plru_arr[s] <= '0;
            end
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid_arr[w] <= '0;
                dirty_arr[w] <= '0;
            end
        end else begin
            cmp_q <= lookup_en;
            if (touch_en) begin
                plru_arr[index][0] <= ~touch_way[1];    // point at the other half
                if (touch_way[1]) begin
                    plru_arr[index][2] <= ~touch_way[0];
                end else begin
                    plru_arr[index][1] <= ~touch_way[0];
                end
            end
            if (fill_valid) begin
                valid_arr[fill_way][index] <= 1'b1;
                dirty_arr[fill_way][index] <= 1'b0;     // fresh line is clean
            end else if (store_commit) begin
                dirty_arr[lookup.hit_way][index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_wr.we) begin
            data_arr[fill_way][index][fill_wr.word] <= fill_wr.data;
        end
        if (fill_valid) begin
            tag_arr[fill_way][index] <= tag;
        end
        if (store_commit) begin
            for (int b = 0; b < `DATA_W/8; b++) begin
                if (cpu_be[b]) begin
                    data_arr[lookup.hit_way][index][word][8*b +: 8] <= cpu_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_ctrl import cache_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cpu_req,
    input  logic    cpu_we,
    input  lookup_t lookup,
    output logic    lookup_en,
    output logic    stall,
    output logic    cpu_done,
    output logic    wb_start,
    output logic    fill_start,
    input  logic    wb_done,
    input  logic    fill_done,
    output logic    store_commit
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL
    } state_t;

    state_t state;
    logic   hit_now;
    logic   miss_now;

    assign hit_now  = (state == LOOKUP) && lookup.hit;
    assign miss_now = (state == LOOKUP) && !lookup.hit;

    // read the set on a new request, and again once the line is in
    assign lookup_en = ((state == IDLE) && cpu_req) ||
                       ((state == REFILL) && fill_done);

    assign cpu_done = hit_now;
    assign stall    = cpu_req && !hit_now;

    // only stores write bytes, the store touches PLRU on every hit itself
    assign store_commit = hit_now && cpu_we;

    // dirty victim goes out before the new line comes in
    assign wb_start   = miss_now && lookup.victim_dirty;
    assign fill_start = (miss_now && !lookup.victim_dirty) ||
                        ((state == WRITEBACK) && wb_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (lookup.hit) begin
                        state <= IDLE;
                    end else if (lookup.victim_dirty) begin
                        state <= WRITEBACK;
                    end else begin
                        state <= REFILL;
                    end
                end
                WRITEBACK: begin
                    if (wb_done) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (fill_done) begin
                        state <= LOOKUP;    // re-run, hits this time
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module dcache_top import cache_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_req,
    input  logic                 cpu_we,
    input  logic [`ADDR_W-1:0]   cpu_addr,
    input  logic [`DATA_W/8-1:0] cpu_be,
    input  logic [`DATA_W-1:0]   cpu_wdata,
    output logic [`DATA_W-1:0]   cpu_rdata,
    output logic                 cpu_done,
    output logic                 stall,
    output logic                 mem_valid,
    output logic                 mem_we,
    output logic                 mem_last,
    output logic [`ADDR_W-1:0]   mem_addr,
    output logic [`DATA_W-1:0]   mem_wdata,
    input  logic                 mem_ready,
    input  logic [`DATA_W-1:0]   mem_rdata
);

    lookup_t            lookup;
    logic               lookup_en;
    logic               store_commit;
    logic               wb_start;
    logic               wb_done;
    logic               fill_start;
    logic               fill_done;
    logic               fill_valid;
    fill_wr_t           fill_wr;
    word_sel_t          wb_word;
    logic [`DATA_W-1:0] wb_rdata;
    logic [`ADDR_W-1:0] line_addr;
    logic [`ADDR_W-1:0] victim_addr;

    mem_port_if wb_bus ();
    mem_port_if fill_bus ();
    mem_port_if mem_bus ();

    // line bases of the requested line and of the victim
    assign line_addr   = {cpu_addr[`ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    assign victim_addr = {lookup.victim_tag, cpu_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W],
                          {`CACHE_OFFSET_W{1'b0}}};

    assign mem_valid       = mem_bus.valid;
    assign mem_we          = mem_bus.beat.we;
    assign mem_addr        = mem_bus.beat.addr;
    assign mem_wdata       = mem_bus.beat.wdata;
    assign mem_last        = mem_bus.beat.last;
    assign mem_bus.ready   = mem_ready;
    assign mem_bus.rdata   = mem_rdata;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_we       (cpu_we),
        .lookup       (lookup),
        .lookup_en    (lookup_en),
        .stall        (stall),
        .cpu_done     (cpu_done),
        .wb_start     (wb_start),
        .fill_start   (fill_start),
        .wb_done      (wb_done),
        .fill_done    (fill_done),
        .store_commit (store_commit)
    );

    cache_store u_store (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (lookup_en),
        .store_commit (store_commit),
        .cpu_we       (cpu_we),
        .cpu_addr     (cpu_addr),
        .cpu_be       (cpu_be),
        .cpu_wdata    (cpu_wdata),
        .lookup       (lookup),
        .cpu_rdata    (cpu_rdata),
        .fill_wr      (fill_wr),
        .fill_way     (lookup.victim_way),  // held stable through the miss
        .fill_valid   (fill_valid),
        .wb_word      (wb_word),
        .wb_rdata     (wb_rdata)
    );

    refill_engine u_refill (
        .clk        (clk),
        .rst        (rst),
        .fill_start (fill_start),
        .line_addr  (line_addr),
        .fill_done  (fill_done),
        .fill_wr    (fill_wr),
        .fill_valid (fill_valid),
        .bus        (fill_bus.requester)
    );

    writeback_engine u_writeback (
        .clk         (clk),
        .rst         (rst),
        .wb_start    (wb_start),
        .victim_addr (victim_addr),
        .wb_done     (wb_done),
        .wb_word     (wb_word),
        .wb_rdata    (wb_rdata),
        .bus         (wb_bus.requester)
    );

    mem_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .wb_port   (wb_bus.arbiter),
        .fill_port (fill_bus.arbiter),
        .mem       (mem_bus.requester)
    );

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter import mem_bus_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    mem_port_if.arbiter   wb_port,
    mem_port_if.arbiter   fill_port,
    mem_port_if.requester mem
);

    requester_t owner;
    requester_t sel;
    logic       locked;     // burst in progress

    // write-back wins when the bus is free
    assign sel = locked ? owner : (wb_port.valid ? WRITEBACK : REFILL);

    assign mem.valid = (sel == WRITEBACK) ? wb_port.valid : fill_port.valid;
    assign mem.beat  = (sel == WRITEBACK) ? wb_port.beat  : fill_port.beat;

    assign wb_port.ready   = mem.ready && (sel == WRITEBACK);
    assign fill_port.ready = mem.ready && (sel == REFILL);
    assign wb_port.rdata   = (sel == WRITEBACK) ? mem.rdata : '0;
    assign fill_port.rdata = (sel == REFILL)    ? mem.rdata : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= WRITEBACK;
        end else if (mem.valid) begin
            if (mem.ready && mem.beat.last) begin
                locked <= 1'b0;     // burst done
            end else begin
                locked <= 1'b1;
                owner  <= sel;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_bus_pkg.sv
`default_nettype none

`include "cache_params.svh"

package mem_bus_pkg;

    typedef enum logic {
        WRITEBACK = 1'b0,
        REFILL    = 1'b1
    } requester_t;

    // address/data phase of one beat
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic               we;
        logic [`DATA_W-1:0] wdata;
        logic               last;   // eighth beat of a burst
    } beat_t;

endpackage

`default_nettype wire

//--- rtl/mem_port_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

interface mem_port_if import mem_bus_pkg::*; ();

    logic               valid;
    beat_t              beat;
    logic               ready;
    logic [`DATA_W-1:0] rdata;  // valid with ready on read beats

    modport requester (
        output valid,
        output beat,
        input  ready,
        input  rdata
    );

    modport arbiter (
        input  valid,
        input  beat,
        output ready,
        output rdata
    );

endinterface

`default_nettype wire

//--- rtl/refill_engine.sv
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module refill_engine import cache_pkg::*; import mem_bus_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               fill_start,
    input  logic [`ADDR_W-1:0] line_addr,
    output logic               fill_done,
    output fill_wr_t           fill_wr,
    output logic               fill_valid,
    mem_port_if.requester      bus
);

    logic      busy;
    word_sel_t cnt;         // next word to read
    logic      last_word;
    logic      fire;
    beat_t     beat;

    assign last_word = (cnt == word_sel_t'(`CACHE_WORDS - 1));
    assign fire      = busy && bus.ready;

    assign beat = '{addr:  {line_addr[`ADDR_W-1:`CACHE_OFFSET_W], cnt, 2'b00},
                    we:    1'b0,
                    wdata: '0,
                    last:  last_word};

    assign bus.valid = busy;
    assign bus.beat  = beat;

    // returned word goes straight into the victim way
    assign fill_wr    = '{we: fire, word: cnt, data: bus.rdata};
    assign fill_valid = fire && last_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            cnt       <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= fill_valid;
            if (fill_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (fire) begin
                cnt <= cnt + 1'b1;
                if (last_word) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/writeback_engine.sv
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module writeback_engine import cache_pkg::*; import mem_bus_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_start,
    input  logic [`ADDR_W-1:0] victim_addr,
    output logic               wb_done,
    output word_sel_t          wb_word,
    input  logic [`DATA_W-1:0] wb_rdata,
    mem_port_if.requester      bus
);

    logic      busy;
    word_sel_t cnt;
    logic      last_word;
    logic      fire;
    beat_t     beat;

    assign last_word = (cnt == word_sel_t'(`CACHE_WORDS - 1));
    assign fire      = busy && bus.ready;

    // word address follows the counter, so it holds under back-pressure
    assign wb_word = cnt;

    assign beat = '{addr:  {victim_addr[`ADDR_W-1:`CACHE_OFFSET_W], cnt, 2'b00},
                    we:    1'b1,
                    wdata: wb_rdata,
                    last:  last_word};

    assign bus.valid = busy;
    assign bus.beat  = beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            cnt     <= '0;
            wb_done <= 1'b0;
        end else begin
            wb_done <= fire && last_word;
            if (wb_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (fire) begin
                cnt <= cnt + 1'b1;
                if (last_word) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module dcache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vdcache_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- tests/dcache_props.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_props (
    input logic        clk,
    input logic        rst,
    input logic        stall,
    input logic        cpu_done,
    input logic        mem_valid,
    input logic        mem_ready,
    input logic        mem_we,
    input logic [31:0] mem_addr,
    input logic [31:0] mem_wdata
);

    // quiet right after reset
    assert property (@(posedge clk) $fell(rst) |-> (!stall && !mem_valid))
        else $error("stall or mem_valid high in the first cycle after reset");

    // back-pressure holds the beat
    assert property (@(posedge clk) disable iff (rst)
        (mem_valid && !mem_ready) |=>
            (mem_valid && $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)))
        else $error("memory beat changed while waiting for mem_ready");

    assert property (@(posedge clk) disable iff (rst) cpu_done |=> !cpu_done)
        else $error("cpu_done high for two cycles in a row");

endmodule

bind dcache_top dcache_props u_props (.*);

`default_nettype wire

//--- tests/dcache_tb.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_tb;

    localparam logic [31:0] FILL_KEY    = 32'h5a5a_0f0f;   // memory word = address ^ key
    localparam logic [31:0] NO_WB       = 32'hffff_ffff;   // no write-back expected
    localparam int          MAX_ENTRIES = 64;
    localparam int          MEM_WORDS   = 4096;

    logic        clk = 1'b0;
    logic        rst;
    logic        cpu_req;
    logic        cpu_we;
    logic [31:0] cpu_addr;
    logic [3:0]  cpu_be;
    logic [31:0] cpu_wdata;
    logic [31:0] cpu_rdata;
    logic        cpu_done;
    logic        stall;
    logic        mem_valid;
    logic        mem_we;
    logic        mem_last;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_ready;
    logic [31:0] mem_rdata;

    logic [31:0] mem [MEM_WORDS];
    logic [7:0]  shadow [MEM_WORDS*4];      // byte-wide processor view

    // reference cache state
    logic [22:0] sh_tag   [16][4];
    logic        sh_val   [16][4];
    logic        sh_dirty [16][4];
    logic [2:0]  sh_plru  [16];

    // stimulus table
    logic        t_we     [MAX_ENTRIES];
    logic [31:0] t_addr   [MAX_ENTRIES];
    logic [3:0]  t_be     [MAX_ENTRIES];
    logic [31:0] t_data   [MAX_ENTRIES];
    logic [31:0] t_exp_wb [MAX_ENTRIES];
    int          n_entries = 0;

    integer      seed = 32'ha4536930;
    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000;
    int          rd_beats;
    int          wr_beats;
    int          wr_at_rd;
    logic [31:0] first_rd;
    logic [31:0] first_wr;

    dcache_top dut (.*);

    always #4 clk = ~clk;

    assign mem_rdata = mem[mem_addr[13:2]];

    always @(negedge clk) begin
        mem_ready <= ($random(seed) & 3) != 0;     // about one stall in four
    end

    function automatic logic [31:0] sh_word(input logic [31:0] a);
        return {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
    endfunction

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("CHECK FAILED t=%0t %s", $time, msg);
            errors++;
        end
    endtask

    task automatic add_entry(input logic we, input logic [31:0] a, input logic [3:0] be,
                             input logic [31:0] d, input logic [31:0] wb);
        t_we[n_entries]     = we;
        t_addr[n_entries]   = a;
        t_be[n_entries]     = be;
        t_data[n_entries]   = d;
        t_exp_wb[n_entries] = wb;
        n_entries++;
    endtask

    // lookup, victim choice and tree update of the reference cache
    task automatic predict(input logic [31:0] a, input logic we,
                           output logic hit, output logic [31:0] wb);
        logic [3:0]  idx;
        logic [22:0] tg;
        logic [1:0]  way;
        idx = a[8:5];
        tg  = a[31:9];
        hit = 1'b0;
        way = 2'd0;
        wb  = NO_WB;
        for (int w = 0; w < 4; w++) begin
            if (sh_val[idx][w] && sh_tag[idx][w] == tg) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
        if (!hit) begin
            way = sh_plru[idx][0] ? {1'b1, sh_plru[idx][2]} : {1'b0, sh_plru[idx][1]};
            if (sh_val[idx][way] && sh_dirty[idx][way]) begin
                wb = {sh_tag[idx][way], idx, 5'b0};
            end
            sh_tag[idx][way]   = tg;
            sh_val[idx][way]   = 1'b1;
            sh_dirty[idx][way] = 1'b0;
        end
        sh_plru[idx][0] = ~way[1];
        if (way[1]) sh_plru[idx][2] = ~way[0];
        else        sh_plru[idx][1] = ~way[0];
        if (we) sh_dirty[idx][way] = 1'b1;
    endtask

    // bus monitor and memory model
    always @(posedge clk) begin
        if (!rst && mem_valid && mem_ready) begin
            if (mem_we) begin
                if (wr_beats == 0) first_wr = mem_addr;
                check(mem_addr == first_wr + 32'(4 * (wr_beats % 8)) &&
                      mem_last == (wr_beats % 8 == 7),
                      $sformatf("write beat %0d addr %h last %b", wr_beats, mem_addr, mem_last));
                check(mem_wdata == sh_word(mem_addr),
                      $sformatf("write-back data %h at %h", mem_wdata, mem_addr));
                mem[mem_addr[13:2]] <= mem_wdata;
                wr_beats++;
            end else begin
                if (rd_beats == 0) begin
                    first_rd = mem_addr;
                    wr_at_rd = wr_beats;
                end
                check(mem_addr == first_rd + 32'(4 * (rd_beats % 8)) &&
                      mem_last == (rd_beats % 8 == 7),
                      $sformatf("read beat %0d addr %h last %b", rd_beats, mem_addr, mem_last));
                rd_beats++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic run_entry(input int i);
        logic        exp_hit;
        logic [31:0] exp_wb;
        logic [31:0] line;
        int          cycles;
        predict(t_addr[i], t_we[i], exp_hit, exp_wb);
        line = {t_addr[i][31:5], 5'b0};
        @(negedge clk);
        rd_beats  = 0;
        wr_beats  = 0;
        wr_at_rd  = 0;
        cpu_req   = 1'b1;
        cpu_we    = t_we[i];
        cpu_addr  = t_addr[i];
        cpu_be    = t_be[i];
        cpu_wdata = t_data[i];
        cycles    = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (!cpu_done) begin
                check(stall, $sformatf("entry %0d stall low while waiting", i));
            end
        end while (!cpu_done);
        check(!stall, $sformatf("entry %0d stall high with cpu_done", i));
        if (!t_we[i]) begin
            check(cpu_rdata == sh_word(t_addr[i]), $sformatf("entry %0d load %h got %h want %h",
                  i, t_addr[i], cpu_rdata, sh_word(t_addr[i])));
        end
        if (exp_hit) begin
            check(cycles == 2, $sformatf("entry %0d hit took %0d cycles", i, cycles));
            check(rd_beats == 0 && wr_beats == 0, $sformatf("entry %0d hit used the bus", i));
        end else begin
            check(rd_beats == 8 && first_rd == line,
                  $sformatf("entry %0d refill %0d beats from %h", i, rd_beats, first_rd));
            check(wr_beats == (exp_wb == NO_WB ? 0 : 8),
                  $sformatf("entry %0d saw %0d write beats", i, wr_beats));
            if (exp_wb != NO_WB) begin
                check(first_wr == exp_wb && wr_at_rd == 8,
                      $sformatf("entry %0d write-back to %h want %h", i, first_wr, exp_wb));
            end
        end
        if (t_exp_wb[i] != NO_WB) begin
            check(exp_wb == t_exp_wb[i] && first_wr == t_exp_wb[i],
                  $sformatf("entry %0d evicted %h want %h", i, first_wr, t_exp_wb[i]));
        end
        if (t_we[i]) begin
            for (int b = 0; b < 4; b++) begin
                if (t_be[i][b]) shadow[t_addr[i] + b] = t_data[i][8*b +: 8];
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_be    = '0;
        cpu_wdata = '0;
        mem_ready = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'(i * 4) ^ FILL_KEY;
            for (int b = 0; b < 4; b++) shadow[i*4 + b] = mem[i][8*b +: 8];
        end
        for (int s = 0; s < 16; s++) begin
            sh_plru[s] = '0;
            for (int w = 0; w < 4; w++) begin
                sh_tag[s][w]   = '0;
                sh_val[s][w]   = 1'b0;
                sh_dirty[s][w] = 1'b0;
            end
        end
        // cold load then byte store and merged reload
        add_entry(1'b0, 32'h0000_0064, 4'hf, 32'h0, NO_WB);
        add_entry(1'b1, 32'h0000_0064, 4'b0101, 32'haabb_ccdd, NO_WB);
        add_entry(1'b0, 32'h0000_0064, 4'hf, 32'h0, NO_WB);
        // five tags in set 5 push out the stored first line
        add_entry(1'b1, 32'h0000_02a0, 4'b1100, 32'h1234_5678, NO_WB);
        add_entry(1'b0, 32'h0000_04a0, 4'hf, 32'h0, NO_WB);
        add_entry(1'b0, 32'h0000_06a0, 4'hf, 32'h0, NO_WB);
        add_entry(1'b0, 32'h0000_08a0, 4'hf, 32'h0, NO_WB);
        add_entry(1'b0, 32'h0000_0aa0, 4'hf, 32'h0, 32'h0000_02a0);
        // dirty set 7 touched in way order 0 3 2 leaves way 1 as victim
        add_entry(1'b1, 32'h0000_02e4, 4'hf, 32'h0101_0101, NO_WB);
        add_entry(1'b1, 32'h0000_04e8, 4'hf, 32'h0202_0202, NO_WB);
        add_entry(1'b1, 32'h0000_06ec, 4'hf, 32'h0303_0303, NO_WB);
        add_entry(1'b1, 32'h0000_08f0, 4'hf, 32'h0404_0404, NO_WB);
        add_entry(1'b0, 32'h0000_02e4, 4'hf, 32'h0, NO_WB);
        add_entry(1'b0, 32'h0000_08f0, 4'hf, 32'h0, NO_WB);
        add_entry(1'b0, 32'h0000_04e8, 4'hf, 32'h0, NO_WB);
        add_entry(1'b0, 32'h0000_0ae0, 4'hf, 32'h0, 32'h0000_06e0);
        // random mix over six tags in each of sets 9 and 10
        for (int k = 0; k < 40; k++) begin
            r = $random(seed);
            a = (32'(r[2:0]) % 6 + 1) * 512 + (r[3] ? 32'd9 : 32'd10) * 32 + 32'(r[6:4]) * 4;
            add_entry(r[12], a, r[11:8], $random(seed), NO_WB);
        end
        cycle_limit = n_entries * 60;

        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        @(negedge clk);
        cpu_req = 1'b0;
        repeat (4) @(negedge clk);
        check(!stall, "stall high with no request pending");

        $display("entries: %0d checks: %0d errors: %0d", n_entries, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
